// ==== Bender.yml ====
package:
  name: fc_top

sources:
  - common/fc_cfg_pkg.sv
  - common/q8_pkg.sv
  - logic/sync_mem.sv
  - fc_engine/fc_sequencer.sv
  - fc_engine/dot_product_unit.sv
  - fc_engine/fc_output_stage.sv
  - fc_engine/fc_top.sv
  - target: simulation
    files:
      - verif/fc_chk.sv
      - verif/fc_tb.sv

// ==== common/fc_cfg_pkg.sv ====
package fc_cfg_pkg;

    // word geometry
    localparam int LANES     = 8;  // bytes per word
    localparam int IN_WORDS  = 4;  // words per input vector

    // layer size
    localparam int OUT_COUNT = 16; // output neurons

    // address widths
    localparam int WT_AW     = $clog2(OUT_COUNT * IN_WORDS);
    localparam int ACT_AW    = $clog2(IN_WORDS);
    localparam int OUT_AW    = $clog2(OUT_COUNT);

endpackage

// ==== common/q8_pkg.sv ====
package q8_pkg;

    localparam int FRAC_BITS = 7; // Q1.7

    typedef logic signed [7:0]  q8_t;
    typedef logic signed [15:0] prod_t;
    typedef logic signed [18:0] lane_sum_t; // LANES products, no rounding
    typedef logic signed [23:0] acc_t;      // IN_WORDS lane sums

    typedef q8_t [fc_cfg_pkg::LANES-1:0] q8_word_t;

    // floor to integer part, add bias, clamp to 0..127
    function automatic q8_t relu_sat(
        input  acc_t total,
        input  q8_t  bias,
        output logic ovf
    );
        acc_t s;
        q8_t  res;
        s   = total >>> FRAC_BITS; // arithmetic shift, takes the floor
        s   = s + acc_t'(bias);
        ovf = 1'b0;
        if (s > 127)
        begin
            res = q8_t'(127);
            ovf = 1'b1;
        end
        else if (s < 0)
        begin
            res = '0; // relu
        end
        else
        begin
            res = q8_t'(s[7:0]);
        end
        return res;
    endfunction

endpackage

// ==== fc_engine/dot_product_unit.sv ====
`timescale 1ns/100ps

module dot_product_unit #(
    parameter int LANES  = fc_cfg_pkg::LANES,
    parameter int OUT_AW = fc_cfg_pkg::OUT_AW
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  q8_pkg::q8_word_t        wt_word,
    input  q8_pkg::q8_word_t        act_word,
    input  logic                    in_valid,
    input  logic                    in_last,
    input  logic [OUT_AW-1:0]       in_row,
    output q8_pkg::lane_sum_t       lane_sum,
    output logic                    lane_valid,
    output logic                    lane_last,
    output logic [OUT_AW-1:0]       lane_row
);

    q8_pkg::prod_t     prod_q [LANES];
    q8_pkg::lane_sum_t sum_c;
    logic              s1_valid;
    logic              s1_last;
    logic [OUT_AW-1:0] s1_row;

    // stage 1, one signed product per lane
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            prod_q[i] <= q8_pkg::prod_t'($signed(wt_word[i]))
                       * q8_pkg::prod_t'($signed(act_word[i]));
        end
        s1_row <= in_row;
    end

    // exact reduction, 19 bits hold eight full-scale products
    always_comb
    begin
        sum_c = '0;
        for (int i = 0; i < LANES; i++)
        begin
            sum_c = sum_c + q8_pkg::lane_sum_t'(prod_q[i]);
        end
    end

    // stage 2
    always_ff @(posedge clk)
    begin
        lane_sum <= sum_c;
        lane_row <= s1_row;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            s1_valid   <= 1'b0;
            s1_last    <= 1'b0;
            lane_valid <= 1'b0;
            lane_last  <= 1'b0;
        end
        else
        begin
            s1_valid   <= in_valid;
            s1_last    <= in_valid && in_last;
            lane_valid <= s1_valid;
            lane_last  <= s1_last;
        end
    end

endmodule

// ==== fc_engine/fc_output_stage.sv ====
`timescale 1ns/100ps

module fc_output_stage #(
    parameter int OUT_AW = fc_cfg_pkg::OUT_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  q8_pkg::lane_sum_t lane_sum,
    input  logic              lane_valid,
    input  logic              lane_last,
    input  logic [OUT_AW-1:0] lane_row,
    input  q8_pkg::q8_t       bias,
    input  logic              run_start,
    output logic              res_we,
    output logic [OUT_AW-1:0] res_waddr,
    output q8_pkg::q8_t       res_wdata,
    output logic              row_done,
    output logic              overflow
);

    q8_pkg::q8_t  bias_d1;
    q8_pkg::q8_t  bias_d2;    // matches dot product latency
    q8_pkg::q8_t  bias_hold;
    q8_pkg::q8_t  eff_bias;
    q8_pkg::q8_t  sat_val;
    q8_pkg::acc_t acc_q;
    q8_pkg::acc_t total;
    logic         first_q;    // next valid word opens a row
    logic         sat_ovf;
    logic         row_end;

    assign row_end  = lane_valid && lane_last;
    assign row_done = res_we;

    always_comb
    begin
        total    = first_q ? q8_pkg::acc_t'(lane_sum)
                           : acc_q + q8_pkg::acc_t'(lane_sum);
        eff_bias = first_q ? bias_d2 : bias_hold;
        sat_val  = q8_pkg::relu_sat(total, eff_bias, sat_ovf);
    end

    always_ff @(posedge clk)
    begin
        bias_d1 <= bias;
        bias_d2 <= bias_d1;
        if (lane_valid)
        begin
            acc_q <= total;
            if (first_q)
            begin
                bias_hold <= bias_d2; // held for the rest of the row
            end
        end
        res_waddr <= lane_row;
        res_wdata <= sat_val;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            res_we   <= 1'b0;
            first_q  <= 1'b1;
            overflow <= 1'b0;
        end
        else
        begin
            res_we <= row_end;
            if (run_start)
            begin
                first_q <= 1'b1;
            end
            else if (lane_valid)
            begin
                first_q <= lane_last;
            end
            if (run_start)
            begin
                overflow <= 1'b0;
            end
            else if (row_end && sat_ovf)
            begin
                overflow <= 1'b1; // sticky until next run
            end
        end
    end

endmodule

// ==== fc_engine/fc_sequencer.sv ====
`timescale 1ns/100ps

module fc_sequencer #(
    parameter int IN_WORDS  = fc_cfg_pkg::IN_WORDS,
    parameter int OUT_COUNT = fc_cfg_pkg::OUT_COUNT,
    parameter int WT_AW     = fc_cfg_pkg::WT_AW,
    parameter int ACT_AW    = fc_cfg_pkg::ACT_AW,
    parameter int OUT_AW    = fc_cfg_pkg::OUT_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic [WT_AW-1:0]  wt_raddr,
    output logic [ACT_AW-1:0] act_raddr,
    output logic [OUT_AW-1:0] bias_raddr,
    output logic              rd_valid,
    output logic              rd_last,
    output logic [OUT_AW-1:0] rd_row,
    input  logic              row_done,
    output logic              busy,
    output logic              done,
    output logic              run_start
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain
    } state_t;

    state_t            state;
    logic [OUT_AW-1:0] row_cnt;
    logic [ACT_AW-1:0] word_cnt;
    logic [OUT_AW-1:0] done_cnt;  // rows retired by the output stage
    logic              last_word;
    logic              last_row;

    assign last_word = (word_cnt == ACT_AW'(IN_WORDS - 1));
    assign last_row  = (row_cnt == OUT_AW'(OUT_COUNT - 1));
    assign run_start = start && (state == st_idle); // start ignored while busy
    assign busy      = (state != st_idle);

    // read addresses follow the counters directly
    assign wt_raddr   = WT_AW'(row_cnt) * WT_AW'(IN_WORDS) + WT_AW'(word_cnt);
    assign act_raddr  = word_cnt;
    assign bias_raddr = row_cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= st_idle;
            row_cnt  <= '0;
            word_cnt <= '0;
            done_cnt <= '0;
            done     <= 1'b0;
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;
            rd_valid <= (state == st_issue); // lines up with memory read data
            rd_last  <= (state == st_issue) && last_word;
            case (state)
                st_idle:
                begin
                    if (start)
                    begin
                        state    <= st_issue;
                        row_cnt  <= '0;
                        word_cnt <= '0;
                        done_cnt <= '0;
                    end
                end
                st_issue:
                begin
                    word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                    if (last_word)
                    begin
                        row_cnt <= row_cnt + 1'b1;
                        if (last_row)
                        begin
                            state <= st_drain;
                        end
                    end
                end
                default: ; // drain, rows retire below
            endcase
            if (busy && row_done)
            begin
                done_cnt <= done_cnt + 1'b1;
                if (done_cnt == OUT_AW'(OUT_COUNT - 1))
                begin
                    state <= st_idle;
                    done  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        rd_row <= row_cnt;
    end

endmodule

// ==== fc_engine/fc_top.sv ====
`timescale 1ns/100ps

module fc_top #(
    parameter int  LANES     = fc_cfg_pkg::LANES,
    parameter int  IN_WORDS  = fc_cfg_pkg::IN_WORDS,
    parameter int  OUT_COUNT = fc_cfg_pkg::OUT_COUNT,
    localparam int WT_AW     = $clog2(OUT_COUNT * IN_WORDS),
    localparam int ACT_AW    = $clog2(IN_WORDS),
    localparam int OUT_AW    = $clog2(OUT_COUNT)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wt_we,
    input  logic [WT_AW-1:0] wt_waddr,
    input  q8_pkg::q8_word_t wt_wdata,
    input  logic             bias_we,
    input  logic [OUT_AW-1:0] bias_waddr,
    input  q8_pkg::q8_t      bias_wdata,
    input  logic             act_we,
    input  logic [ACT_AW-1:0] act_waddr,
    input  q8_pkg::q8_word_t act_wdata,
    input  logic             start,
    input  logic [OUT_AW-1:0] res_raddr,
    output q8_pkg::q8_t      res_rdata,
    output logic             busy,
    output logic             done,
    output logic             overflow
);

    logic [WT_AW-1:0]  wt_raddr;
    logic [ACT_AW-1:0] act_raddr;
    logic [OUT_AW-1:0] bias_raddr;
    q8_pkg::q8_word_t  wt_rdata;
    q8_pkg::q8_word_t  act_rdata;
    q8_pkg::q8_t       bias_rdata;
    logic              rd_valid;
    logic              rd_last;
    logic [OUT_AW-1:0] rd_row;
    q8_pkg::lane_sum_t lane_sum;
    logic              lane_valid;
    logic              lane_last;
    logic [OUT_AW-1:0] lane_row;
    logic              res_we;
    logic [OUT_AW-1:0] res_waddr;
    q8_pkg::q8_t       res_wdata;
    logic              row_done;
    logic              run_start;

    sync_mem #(.data_t(q8_pkg::q8_word_t), .DEPTH(OUT_COUNT * IN_WORDS), .AW(WT_AW)) wt_mem_i (
        .clk(clk), .we(wt_we), .waddr(wt_waddr), .wdata(wt_wdata),
        .raddr(wt_raddr), .rdata(wt_rdata)
    );

    sync_mem #(.data_t(q8_pkg::q8_word_t), .DEPTH(IN_WORDS), .AW(ACT_AW)) act_mem_i (
        .clk(clk), .we(act_we), .waddr(act_waddr), .wdata(act_wdata),
        .raddr(act_raddr), .rdata(act_rdata)
    );

    sync_mem #(.data_t(q8_pkg::q8_t), .DEPTH(OUT_COUNT), .AW(OUT_AW)) bias_mem_i (
        .clk(clk), .we(bias_we), .waddr(bias_waddr), .wdata(bias_wdata),
        .raddr(bias_raddr), .rdata(bias_rdata)
    );

    sync_mem #(.data_t(q8_pkg::q8_t), .DEPTH(OUT_COUNT), .AW(OUT_AW)) res_mem_i (
        .clk(clk), .we(res_we), .waddr(res_waddr), .wdata(res_wdata),
        .raddr(res_raddr), .rdata(res_rdata)
    );

    fc_sequencer #(
        .IN_WORDS(IN_WORDS), .OUT_COUNT(OUT_COUNT),
        .WT_AW(WT_AW), .ACT_AW(ACT_AW), .OUT_AW(OUT_AW)
    ) seq_i (
        .clk(clk), .rst_n(rst_n), .start(start),
        .wt_raddr(wt_raddr), .act_raddr(act_raddr), .bias_raddr(bias_raddr),
        .rd_valid(rd_valid), .rd_last(rd_last), .rd_row(rd_row),
        .row_done(row_done), .busy(busy), .done(done), .run_start(run_start)
    );

    dot_product_unit #(.LANES(LANES), .OUT_AW(OUT_AW)) dpu_i (
        .clk(clk), .rst_n(rst_n),
        .wt_word(wt_rdata), .act_word(act_rdata),
        .in_valid(rd_valid), .in_last(rd_last), .in_row(rd_row),
        .lane_sum(lane_sum), .lane_valid(lane_valid),
        .lane_last(lane_last), .lane_row(lane_row)
    );

    fc_output_stage #(.OUT_AW(OUT_AW)) out_i (
        .clk(clk), .rst_n(rst_n),
        .lane_sum(lane_sum), .lane_valid(lane_valid),
        .lane_last(lane_last), .lane_row(lane_row),
        .bias(bias_rdata), .run_start(run_start),
        .res_we(res_we), .res_waddr(res_waddr), .res_wdata(res_wdata),
        .row_done(row_done), .overflow(overflow)
    );

endmodule

// ==== fc_top.f ====
common/fc_cfg_pkg.sv
common/q8_pkg.sv
logic/sync_mem.sv
fc_engine/fc_sequencer.sv
fc_engine/dot_product_unit.sv
fc_engine/fc_output_stage.sv
fc_engine/fc_top.sv
verif/fc_chk.sv
verif/fc_tb.sv

// ==== logic/sync_mem.sv ====
`timescale 1ns/100ps

module sync_mem #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 16,
    parameter int  AW     = 4
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  data_t         wdata,
    input  logic [AW-1:0] raddr,
    output data_t         rdata
);

    data_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // registered read
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// ==== verif/fc_chk.sv ====
`timescale 1ns/100ps

module fc_chk (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done,
    input logic overflow,
    input logic wt_we,
    input logic bias_we,
    input logic act_we
);

    // memories are loaded only while idle
    assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !(wt_we || bias_we || act_we))
        else $error("write strobe seen while busy");

    assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy && $past(busy))
        else $error("done pulse not at the end of busy");

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> done)
        else $error("busy fell without done");

    assert property (@(posedge clk) disable iff (!rst_n)
        start && !busy |=> !overflow)
        else $error("overflow not cleared by start");

endmodule

// ==== verif/fc_tb.sv ====
`timescale 1ns/100ps

module fc_tb;

    localparam int LANES        = fc_cfg_pkg::LANES;
    localparam int IN_WORDS     = fc_cfg_pkg::IN_WORDS;
    localparam int OUT_COUNT    = fc_cfg_pkg::OUT_COUNT;
    localparam int WT_AW        = fc_cfg_pkg::WT_AW;
    localparam int ACT_AW       = fc_cfg_pkg::ACT_AW;
    localparam int OUT_AW       = fc_cfg_pkg::OUT_AW;
    localparam int WT_DEPTH     = OUT_COUNT * IN_WORDS;
    localparam int RUN_CYCLES   = OUT_COUNT * IN_WORDS + 4; // issue, memory, dot product, output
    localparam int DONE_TIMEOUT = 200;
    localparam int NUM_CASES    = 5;
    localparam integer SEED_BASE = 32'h98c55292;

    localparam int MODE_SMALL = 0; // -16..15
    localparam int MODE_LARGE = 1; // 100..127
    localparam int MODE_NEG   = 2; // -128..-121 for biases only
    localparam int MODE_KEEP  = 3; // weights from the previous case

    typedef struct {
        int wt_mode;
        int act_mode;
        int bias_mode;
        int seed_ofs;
    } case_t;

    case_t cases [NUM_CASES] = '{
        '{MODE_SMALL, MODE_SMALL, MODE_SMALL, 0},
        '{MODE_SMALL, MODE_SMALL, MODE_NEG,   1},  // all results clamp to 0
        '{MODE_LARGE, MODE_LARGE, MODE_SMALL, 2},  // all results saturate
        '{MODE_SMALL, MODE_SMALL, MODE_SMALL, 3},
        '{MODE_KEEP,  MODE_SMALL, MODE_SMALL, 4}   // new activations only
    };

    logic              clk;
    logic              rst_n;
    logic              wt_we;
    logic [WT_AW-1:0]  wt_waddr;
    q8_pkg::q8_word_t  wt_wdata;
    logic              bias_we;
    logic [OUT_AW-1:0] bias_waddr;
    q8_pkg::q8_t       bias_wdata;
    logic              act_we;
    logic [ACT_AW-1:0] act_waddr;
    q8_pkg::q8_word_t  act_wdata;
    logic              start;
    logic [OUT_AW-1:0] res_raddr;
    q8_pkg::q8_t       res_rdata;
    logic              busy;
    logic              done;
    logic              overflow;

    q8_pkg::q8_word_t  wt_model [WT_DEPTH];
    q8_pkg::q8_word_t  act_model [IN_WORDS];
    q8_pkg::q8_t       bias_model [OUT_COUNT];
    q8_pkg::q8_t       exp_res [OUT_COUNT];
    logic              exp_ovf;
    integer            seed;
    int                value_errors = 0;
    int                timeout_errors = 0;
    int                done_seen = 0;
    int                cycle_no = 0;

    fc_top #(.LANES(LANES), .IN_WORDS(IN_WORDS), .OUT_COUNT(OUT_COUNT)) fc_top_i (
        .clk(clk), .rst_n(rst_n),
        .wt_we(wt_we), .wt_waddr(wt_waddr), .wt_wdata(wt_wdata),
        .bias_we(bias_we), .bias_waddr(bias_waddr), .bias_wdata(bias_wdata),
        .act_we(act_we), .act_waddr(act_waddr), .act_wdata(act_wdata),
        .start(start), .res_raddr(res_raddr), .res_rdata(res_rdata),
        .busy(busy), .done(done), .overflow(overflow)
    );

    bind fc_top fc_chk chk_i (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done),
        .overflow(overflow), .wt_we(wt_we), .bias_we(bias_we), .act_we(act_we)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_no <= cycle_no + 1;
    end

    always @(negedge clk)
    begin
        if (rst_n && done)
        begin
            done_seen = done_seen + 1;
        end
    end

    function automatic q8_pkg::q8_t rand_in(input int lo, input int hi);
        int r;
        r = {$random(seed)} % (hi - lo + 1);
        return q8_pkg::q8_t'(lo + r);
    endfunction

    function automatic q8_pkg::q8_t pick(input int mode);
        case (mode)
            MODE_SMALL: return rand_in(-16, 15);
            MODE_LARGE: return rand_in(100, 127);
            MODE_NEG:   return rand_in(-128, -121);
            default:    return '0;
        endcase
    endfunction

    task automatic check_q8(input string name, input q8_pkg::q8_t got, input q8_pkg::q8_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: expected %h got %h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: expected %h got %h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("[ERROR] %s: expected %h got %h", name, exp, got);
            value_errors++;
        end
    endtask

    task automatic fill_model(input case_t c);
        seed = SEED_BASE + c.seed_ofs;
        for (int a = 0; a < WT_DEPTH; a++)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (c.wt_mode != MODE_KEEP)
                begin
                    wt_model[a][l] = pick(c.wt_mode);
                end
            end
        end
        for (int w = 0; w < IN_WORDS; w++)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                act_model[w][l] = pick(c.act_mode);
            end
        end
        for (int n = 0; n < OUT_COUNT; n++)
        begin
            bias_model[n] = pick(c.bias_mode);
        end
    endtask

    // Q1.7 total floored, biased and clamped to 0..127
    task automatic predict();
        int total;
        int s;
        exp_ovf = 1'b0;
        for (int r = 0; r < OUT_COUNT; r++)
        begin
            total = 0;
            for (int w = 0; w < IN_WORDS; w++)
            begin
                for (int l = 0; l < LANES; l++)
                begin
                    total += int'($signed(wt_model[r * IN_WORDS + w][l]))
                           * int'($signed(act_model[w][l]));
                end
            end
            s = (total >>> q8_pkg::FRAC_BITS) + int'($signed(bias_model[r]));
            if (s > 127)
            begin
                exp_res[r] = 8'sd127;
                exp_ovf    = 1'b1;
            end
            else if (s < 0)
            begin
                exp_res[r] = '0;
            end
            else
            begin
                exp_res[r] = q8_pkg::q8_t'(s);
            end
        end
    endtask

    task automatic load_dut(input bit load_wt);
        for (int a = 0; a < WT_DEPTH; a++)
        begin
            if (load_wt)
            begin
                @(posedge clk);
                wt_we    <= 1'b1;
                wt_waddr <= WT_AW'(a);
                wt_wdata <= wt_model[a];
            end
        end
        for (int w = 0; w < IN_WORDS; w++)
        begin
            @(posedge clk);
            wt_we     <= 1'b0;
            act_we    <= 1'b1;
            act_waddr <= ACT_AW'(w);
            act_wdata <= act_model[w];
        end
        for (int n = 0; n < OUT_COUNT; n++)
        begin
            @(posedge clk);
            act_we     <= 1'b0;
            bias_we    <= 1'b1;
            bias_waddr <= OUT_AW'(n);
            bias_wdata <= bias_model[n];
        end
        @(posedge clk);
        bias_we <= 1'b0;
    endtask

    task automatic run_case(input case_t c, input int idx);
        int cycles;
        int start_cycle;
        fill_model(c);
        predict();
        load_dut(c.wt_mode != MODE_KEEP);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        start_cycle = cycle_no;
        check_flag("busy", busy, 1'b1);
        check_flag("overflow", overflow, 1'b0);
        repeat (4) @(posedge clk);
        start <= 1'b1; // lands while busy and must be ignored
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
        begin
            $display("case %0d: done never arrived", idx);
            timeout_errors++;
        end
        else
        begin
            check_count("run latency", cycle_no - start_cycle, RUN_CYCLES);
        end
        check_flag("busy", busy, 1'b0);
        check_flag("overflow", overflow, exp_ovf);
        @(negedge clk);
        check_flag("done", done, 1'b0);
        for (int n = 0; n < OUT_COUNT; n++)
        begin
            @(posedge clk);
            res_raddr <= OUT_AW'(n);
            @(posedge clk); // one cycle read latency
            @(negedge clk);
            check_q8($sformatf("res_rdata[%0d]", n), res_rdata, exp_res[n]);
        end
        check_count("done pulses", done_seen, idx + 1);
    endtask

    initial
    begin
        seed       = SEED_BASE;
        rst_n      = 1'b0;
        start      = 1'b0;
        wt_we      = 1'b0;
        wt_waddr   = '0;
        wt_wdata   = '0;
        bias_we    = 1'b0;
        bias_waddr = '0;
        bias_wdata = '0;
        act_we     = 1'b0;
        act_waddr  = '0;
        act_wdata  = '0;
        res_raddr  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < NUM_CASES; i++)
        begin
            run_case(cases[i], i);
        end
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
